//--- rtl/prefix_pkg.sv
package prefix_pkg;

    // a single byte as it arrives from the instruction stream
    typedef logic [7:0] instr_byte_t;

    // segment register number as this decoder encodes it
    // cs is 0, ds is 2, ss is 3, fs is 4 and gs is 5
    typedef logic [2:0] seg_id_t;

    // count of prefix bytes seen ahead of one opcode
    // the scanner stops counting once it reaches its configured limit
    typedef logic [3:0] prefix_cnt_t;

    // the ds encoding is what an instruction uses when it carries no segment prefix
    localparam seg_id_t seg_default = 3'd2;

    // one decoded instruction as it travels from scanner to queue to issue stage
    typedef struct packed {
        instr_byte_t opcode;
        // an f2 byte was seen
        logic        rep;
        // a 66 byte was seen, which selects 16 bit operands
        logic        op_override;
        // at least one segment prefix was seen
        logic        seg_override;
        // segment of the last segment prefix that only matters with seg_override
        seg_id_t     seg_id;
        prefix_cnt_t prefix_cnt;
        // more prefixes arrived than the scanner was allowed to count
        logic        prefix_overflow;
    } instr_rec_t;

    // the scanner sits in idle between instructions
    // and moves to in_prefix once the first prefix byte is taken
    typedef enum logic {
        idle,
        in_prefix
    } scan_state_t;

endpackage

//--- rtl/prefix_checker.sv
`timescale 1ns/100ps

module prefix_checker import prefix_pkg::*; (
    input  instr_byte_t instr_byte,
    output logic        is_prefix,
    output logic        is_opcode,
    output logic        operand_override,
    output logic        segment_override,
    output logic        repeat_prefix,
    output seg_id_t     seg_id
);

    // product terms of the decode table
    // each one is computed once and shared by every output that needs it
    logic t_rep;
    logic t_fs_gs;
    logic t_cs_ds;
    logic t_op;
    logic t_ss_ds;

    // f2 is the only repeat prefix recognised here and f3 falls through to opcode
    assign t_rep = instr_byte[7] & instr_byte[6] & instr_byte[5] & instr_byte[4]
                 & ~instr_byte[3] & ~instr_byte[2] & instr_byte[1] & ~instr_byte[0];

    // 64 and 65 both match with bit 0 left free
    assign t_fs_gs = ~instr_byte[7] & instr_byte[6] & instr_byte[5] & ~instr_byte[4]
                   & ~instr_byte[3] & instr_byte[2] & ~instr_byte[1];

    // 2e and 3e both match with bit 4 left free
    assign t_cs_ds = ~instr_byte[7] & ~instr_byte[6] & instr_byte[5] & instr_byte[3]
                   & instr_byte[2] & instr_byte[1] & ~instr_byte[0];

    // 66 selects the short operand size
    assign t_op = ~instr_byte[7] & instr_byte[6] & instr_byte[5] & ~instr_byte[4]
                & ~instr_byte[3] & instr_byte[2] & instr_byte[1] & ~instr_byte[0];

    // 36 and 3e both match with bit 3 left free
    assign t_ss_ds = ~instr_byte[7] & ~instr_byte[6] & instr_byte[5] & instr_byte[4]
                   & instr_byte[2] & instr_byte[1] & ~instr_byte[0];

    // any of the five terms makes the byte a prefix
    assign is_prefix = t_rep | t_fs_gs | t_cs_ds | t_op | t_ss_ds;
    assign is_opcode = ~is_prefix;

    assign operand_override = t_op;
    assign repeat_prefix    = t_rep;
    assign segment_override = t_fs_gs | t_cs_ds | t_ss_ds;

    // bit 2 marks the fs/gs pair and bit 1 the 36/3e pair
    // 3e hits both cs/ds and ss/ds terms and so lands on 2, which is ds
    assign seg_id[2] = t_fs_gs;
    assign seg_id[1] = t_ss_ds;

    // bit 0 separates gs from fs, and ss from ds through bit 3 of the byte
    assign seg_id[0] = (t_fs_gs & instr_byte[0]) | (t_ss_ds & ~instr_byte[3]);

endmodule

//--- rtl/prefix_scanner.sv
`timescale 1ns/100ps

module prefix_scanner import prefix_pkg::*; #(
    parameter int unsigned max_prefixes = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        byte_valid,
    input  instr_byte_t byte_data,
    input  logic        stall,
    output logic        rec_valid,
    output instr_rec_t  rec,
    output logic        byte_dropped
);

    // the count stops at this value and further prefixes only raise overflow
    localparam prefix_cnt_t cnt_limit = prefix_cnt_t'(max_prefixes);

    scan_state_t state;

    // prefix summary gathered so far for the instruction in progress
    logic        acc_rep;
    logic        acc_op;
    logic        acc_seg;
    logic        acc_ovf;
    seg_id_t     acc_seg_id;
    prefix_cnt_t acc_cnt;

    // summary that the current byte builds on
    logic        base_rep;
    logic        base_op;
    logic        base_seg;
    logic        base_ovf;
    seg_id_t     base_seg_id;
    prefix_cnt_t base_cnt;

    // summary after the current byte that is kept only when the byte is a prefix
    logic        nxt_rep;
    logic        nxt_op;
    logic        nxt_seg;
    logic        nxt_ovf;
    seg_id_t     nxt_seg_id;
    prefix_cnt_t nxt_cnt;

    logic    is_prefix;
    logic    is_opcode;
    logic    operand_override;
    logic    segment_override;
    logic    repeat_prefix;
    seg_id_t chk_seg_id;
    logic    take;

    prefix_checker u_prefix_checker (
        .instr_byte       (byte_data),
        .is_prefix        (is_prefix),
        .is_opcode        (is_opcode),
        .operand_override (operand_override),
        .segment_override (segment_override),
        .repeat_prefix    (repeat_prefix),
        .seg_id           (chk_seg_id)
    );

    // a byte only counts when the queue has room for its record
    assign take = byte_valid & ~stall;

    always_comb begin
        // in idle a new instruction starts from an empty summary
        if (state == in_prefix) begin
            base_rep    = acc_rep;
            base_op     = acc_op;
            base_seg    = acc_seg;
            base_seg_id = acc_seg_id;
            base_cnt    = acc_cnt;
            base_ovf    = acc_ovf;
        end else begin
            base_rep    = 1'b0;
            base_op     = 1'b0;
            base_seg    = 1'b0;
            base_seg_id = '0;
            base_cnt    = '0;
            base_ovf    = 1'b0;
        end
        nxt_rep = base_rep | repeat_prefix;
        nxt_op  = base_op | operand_override;
        nxt_seg = base_seg | segment_override;
        // a later segment prefix replaces whatever segment came before
        nxt_seg_id = segment_override ? chk_seg_id : base_seg_id;
        // repeated prefixes still count up to the limit
        if (base_cnt == cnt_limit) begin
            nxt_cnt = base_cnt;
            nxt_ovf = 1'b1;
        end else begin
            nxt_cnt = base_cnt + prefix_cnt_t'(1);
            nxt_ovf = base_ovf;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= idle;
            acc_rep      <= 1'b0;
            acc_op       <= 1'b0;
            acc_seg      <= 1'b0;
            acc_seg_id   <= '0;
            acc_cnt      <= '0;
            acc_ovf      <= 1'b0;
            rec_valid    <= 1'b0;
            byte_dropped <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            // the drop flag stays set until the next reset
            if (byte_valid && stall) begin
                byte_dropped <= 1'b1;
            end
            if (take && is_prefix) begin
                state      <= in_prefix;
                acc_rep    <= nxt_rep;
                acc_op     <= nxt_op;
                acc_seg    <= nxt_seg;
                acc_seg_id <= nxt_seg_id;
                acc_cnt    <= nxt_cnt;
                acc_ovf    <= nxt_ovf;
            end else if (take) begin
                // the opcode closes the instruction
                state      <= idle;
                acc_rep    <= 1'b0;
                acc_op     <= 1'b0;
                acc_seg    <= 1'b0;
                acc_seg_id <= '0;
                acc_cnt    <= '0;
                acc_ovf    <= 1'b0;
                rec_valid  <= 1'b1;
            end
        end
    end

    // the record payload is qualified by rec_valid in the following cycle
    always_ff @(posedge clk) begin
        if (take && is_opcode) begin
            rec.opcode          <= byte_data;
            rec.rep             <= base_rep;
            rec.op_override     <= base_op;
            rec.seg_override    <= base_seg;
            rec.seg_id          <= base_seg_id;
            rec.prefix_cnt      <= base_cnt;
            rec.prefix_overflow <= base_ovf;
        end
    end

endmodule

//--- rtl/instr_queue.sv
`timescale 1ns/100ps

module instr_queue import prefix_pkg::*; #(
    parameter int unsigned queue_depth = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr,
    input  instr_rec_t wr_rec,
    input  logic       pop,
    output instr_rec_t rd_rec,
    output logic       empty,
    output logic       stall
);

    localparam int unsigned ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int unsigned occ_w = $clog2(queue_depth + 1);

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [occ_w-1:0] occ_t;

    // pointers wrap here, so depths that are not a power of two work too
    localparam ptr_t last_slot = ptr_t'(queue_depth - 1);
    localparam occ_t occ_full  = occ_t'(queue_depth);
    // one slot is kept back for the record the scanner may still be building
    localparam occ_t occ_stall = occ_t'(queue_depth - 1);

    instr_rec_t mem [queue_depth];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    occ_t       occ;
    logic       full;
    logic       do_wr;
    logic       do_rd;

    function automatic ptr_t ptr_next(input ptr_t p);
        ptr_t n;
        if (p == last_slot) begin
            n = '0;
        end else begin
            n = p + ptr_t'(1);
        end
        return n;
    endfunction

    assign empty = (occ == '0);
    assign full  = (occ == occ_full);
    assign stall = (occ >= occ_stall);

    // the stall margin keeps the queue from filling and the full gate is a last guard
    assign do_wr = wr & ~full;
    assign do_rd = pop & ~empty;

    // the head is visible while pop is asserted and moves on at that edge
    assign rd_rec = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // a write and a pop together leave the occupancy unchanged
            case ({do_wr, do_rd})
                2'b10:   occ <= occ + occ_t'(1);
                2'b01:   occ <= occ - occ_t'(1);
                default: occ <= occ;
            endcase
        end
    end

    // the slot at the write pointer takes the incoming record
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

endmodule

//--- rtl/prefix_issue.sv
`timescale 1ns/100ps

module prefix_issue import prefix_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       issue_en,
    input  logic       empty,
    input  instr_rec_t rd_rec,
    output logic       pop,
    output logic       issue_valid,
    output instr_rec_t issue_rec,
    output seg_id_t    eff_seg,
    output logic       op_size_16
);

    // effective segment of the head record before it is registered
    seg_id_t head_seg;

    // take one record per cycle whenever downstream allows it and one is waiting
    assign pop = issue_en & ~empty;

    // without a segment prefix the instruction addresses through ds
    assign head_seg = rd_rec.seg_override ? rd_rec.seg_id : seg_default;

    // issue_valid is high for exactly the cycle after each pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= pop;
        end
    end

    // resolved fields travel with issue_valid and hold between pops
    always_ff @(posedge clk) begin
        if (pop) begin
            issue_rec <= rd_rec;
            eff_seg   <= head_seg;
            // the default operand size is 32, and 66 drops it to 16
            op_size_16 <= rd_rec.op_override;
        end
    end

endmodule

//--- rtl/prefix_decode_top.sv
`timescale 1ns/100ps

module prefix_decode_top import prefix_pkg::*; #(
    parameter int unsigned max_prefixes = 4,
    parameter int unsigned queue_depth  = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        byte_valid,
    input  instr_byte_t byte_data,
    input  logic        issue_en,
    output logic        stall,
    output logic        byte_dropped,
    output logic        issue_valid,
    output instr_rec_t  issue_rec,
    output seg_id_t     eff_seg,
    output logic        op_size_16
);

    // scanner to queue
    logic       scan_rec_valid;
    instr_rec_t scan_rec;

    // queue to issue stage and back
    logic       q_empty;
    instr_rec_t q_rd_rec;
    logic       q_pop;

    // stall goes both to the byte source and to the scanner
    prefix_scanner #(
        .max_prefixes (max_prefixes)
    ) u_prefix_scanner (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .stall        (stall),
        .rec_valid    (scan_rec_valid),
        .rec          (scan_rec),
        .byte_dropped (byte_dropped)
    );

    instr_queue #(
        .queue_depth (queue_depth)
    ) u_instr_queue (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (scan_rec_valid),
        .wr_rec (scan_rec),
        .pop    (q_pop),
        .rd_rec (q_rd_rec),
        .empty  (q_empty),
        .stall  (stall)
    );

    prefix_issue u_prefix_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_en    (issue_en),
        .empty       (q_empty),
        .rd_rec      (q_rd_rec),
        .pop         (q_pop),
        .issue_valid (issue_valid),
        .issue_rec   (issue_rec),
        .eff_seg     (eff_seg),
        .op_size_16  (op_size_16)
    );

endmodule

//--- dv/prefix_decode_tb.sv
`timescale 1ns/100ps

module prefix_decode_tb import prefix_pkg::*; ();

    localparam int unsigned max_prefixes = 4;
    localparam int unsigned queue_depth  = 8;

    // instruction counts per test set the watchdog limit
    localparam int n_directed  = 8;
    localparam int n_rand      = 200;
    localparam int n_bp        = 12;
    localparam int n_fill      = queue_depth + 2;
    localparam int total_instr = n_directed + n_rand + n_bp + n_fill;
    localparam int watchdog_ns = total_instr * 400 + 2000;

    // what the issue stage should present for one instruction
    typedef struct packed {
        instr_rec_t rec;
        seg_id_t    seg;
        logic       op16;
    } expect_t;

    typedef instr_byte_t byte_q_t [$];

    logic        clk;
    logic        rst_n;
    logic        byte_valid;
    instr_byte_t byte_data;
    logic        issue_en;
    logic        stall;
    logic        byte_dropped;
    logic        issue_valid;
    instr_rec_t  issue_rec;
    seg_id_t     eff_seg;
    logic        op_size_16;

    // expected records in issue order along with the name of the test that sent each one
    expect_t exp_q [$];
    string   name_q [$];

    int      n_fail;
    int      n_other;
    int      n_sent;
    int      n_issued;
    expect_t cur_exp;
    string   cur_name;
    byte_q_t seq;
    int      n_pfx;
    int      pick;
    logic    stall_seen;
    logic    bp_done;
    instr_byte_t rnd_byte;

    prefix_decode_top #(
        .max_prefixes (max_prefixes),
        .queue_depth  (queue_depth)
    ) u_prefix_decode_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .issue_en     (issue_en),
        .stall        (stall),
        .byte_dropped (byte_dropped),
        .issue_valid  (issue_valid),
        .issue_rec    (issue_rec),
        .eff_seg      (eff_seg),
        .op_size_16   (op_size_16)
    );

    always #2 clk = ~clk;

    // compares one value and reports a mismatch with the test name
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected 0x%0h actual 0x%0h", name, exp, act);
            n_fail++;
        end
    endtask

    // decode table for the seven recognised prefixes
    function automatic bit is_prefix_byte(input instr_byte_t b);
        case (b)
            8'hf2, 8'h66, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic instr_byte_t prefix_by_index(input int idx);
        case (idx)
            0: return 8'hf2;
            1: return 8'h66;
            2: return 8'h2e;
            3: return 8'h36;
            4: return 8'h3e;
            5: return 8'h64;
            default: return 8'h65;
        endcase
    endfunction

    // expected summary of one instruction whose last byte is the opcode
    function automatic expect_t ref_model(input byte_q_t bytes);
        expect_t e;
        int      last;
        e = '0;
        last = bytes.size() - 1;
        for (int i = 0; i < last; i++) begin
            case (bytes[i])
                8'hf2: e.rec.rep = 1'b1;
                8'h66: e.rec.op_override = 1'b1;
                8'h2e: begin
                    e.rec.seg_override = 1'b1;
                    e.rec.seg_id = 3'd0;
                end
                8'h3e: begin
                    e.rec.seg_override = 1'b1;
                    e.rec.seg_id = 3'd2;
                end
                8'h36: begin
                    e.rec.seg_override = 1'b1;
                    e.rec.seg_id = 3'd3;
                end
                8'h64: begin
                    e.rec.seg_override = 1'b1;
                    e.rec.seg_id = 3'd4;
                end
                default: begin
                    e.rec.seg_override = 1'b1;
                    e.rec.seg_id = 3'd5;
                end
            endcase
            // every prefix counts and the count holds at the limit once reached
            if (int'(e.rec.prefix_cnt) == max_prefixes) begin
                e.rec.prefix_overflow = 1'b1;
            end else begin
                e.rec.prefix_cnt = e.rec.prefix_cnt + 4'd1;
            end
        end
        e.rec.opcode = bytes[last];
        // ds is the segment of an instruction with no segment prefix
        e.seg  = e.rec.seg_override ? e.rec.seg_id : 3'd2;
        e.op16 = e.rec.op_override;
        return e;
    endfunction

    // the strobe is raised and dropped 0.5 ns after a rising edge and held off during stall
    task automatic send_byte(input instr_byte_t b);
        while (stall) begin
            byte_valid = 1'b0;
            @(posedge clk);
            #0.5;
        end
        byte_valid = 1'b1;
        byte_data  = b;
        @(posedge clk);
        #0.5;
        byte_valid = 1'b0;
    endtask

    task automatic send_instr(input byte_q_t bytes, input string name);
        expect_t e;
        e = ref_model(bytes);
        exp_q.push_back(e);
        name_q.push_back(name);
        n_sent++;
        foreach (bytes[i]) begin
            send_byte(bytes[i]);
        end
    endtask

    // records are checked at the falling edge where the registered outputs are settled
    always @(negedge clk) begin
        if (rst_n && issue_valid) begin
            if (exp_q.size() == 0) begin
                $display("a record was issued while no instruction was outstanding");
                n_other++;
            end else begin
                cur_exp  = exp_q.pop_front();
                cur_name = name_q.pop_front();
                check_value({cur_name, " record"}, 32'(cur_exp.rec), 32'(issue_rec));
                check_value({cur_name, " eff_seg"}, 32'(cur_exp.seg), 32'(eff_seg));
                check_value({cur_name, " op_size_16"}, 32'(cur_exp.op16), 32'(op_size_16));
                n_issued++;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not complete within %0d ns", watchdog_ns);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        byte_data  = '0;
        issue_en   = 1'b0;
        n_fail     = 0;
        n_other    = 0;
        n_sent     = 0;
        n_issued   = 0;
        stall_seen = 1'b0;
        bp_done    = 1'b0;
        void'($urandom(33));
        repeat (2) @(posedge clk);
        #0.5;
        rst_n    = 1'b1;
        issue_en = 1'b1;

        // idle outputs after reset with nothing sent
        repeat (2) @(posedge clk);
        #0.5;
        check_value("reset stall", 32'd0, 32'(stall));
        check_value("reset byte_dropped", 32'd0, 32'(byte_dropped));
        check_value("reset issue_valid", 32'd0, 32'(issue_valid));

        // each prefix alone ahead of nop and then a bare nop
        for (int i = 0; i < n_directed; i++) begin
            seq.delete();
            if (i < 7) begin
                seq.push_back(prefix_by_index(i));
            end
            seq.push_back(8'h90);
            send_instr(seq, "directed");
        end

        // random prefix runs end on 26, f3 or another non-prefix byte
        for (int k = 0; k < n_rand; k++) begin
            seq.delete();
            n_pfx = $urandom_range(0, 6);
            for (int j = 0; j < n_pfx; j++) begin
                seq.push_back(prefix_by_index($urandom_range(0, 6)));
            end
            pick = $urandom_range(0, 3);
            if (pick == 0) begin
                seq.push_back(8'h26);
            end else if (pick == 1) begin
                seq.push_back(8'hf3);
            end else begin
                rnd_byte = 8'($urandom_range(0, 255));
                while (is_prefix_byte(rnd_byte)) begin
                    rnd_byte = 8'($urandom_range(0, 255));
                end
                seq.push_back(rnd_byte);
            end
            send_instr(seq, "random");
        end

        // under back-pressure the queue fills with issue blocked and is released later
        issue_en = 1'b0;
        fork
            begin
                for (int k = 0; k < n_bp; k++) begin
                    seq.delete();
                    seq.push_back(prefix_by_index(k % 7));
                    seq.push_back(8'(8'h10 + k));
                    send_instr(seq, "backpressure");
                end
                bp_done = 1'b1;
            end
            begin
                wait (stall || bp_done);
                stall_seen = stall;
                repeat (16) @(posedge clk);
                #0.5;
                issue_en = 1'b1;
            end
        join
        check_value("backpressure stall seen", 32'd1, 32'(stall_seen));

        // let the queue drain before it is filled again
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #0.5;

        // fill until stall and then offer one byte that must be dropped
        issue_en = 1'b0;
        for (int k = 0; k < n_fill && !stall; k++) begin
            seq.delete();
            seq.push_back(8'(8'h40 + k));
            send_instr(seq, "drop");
        end
        repeat (3) @(posedge clk);
        #0.5;
        check_value("drop stall", 32'd1, 32'(stall));
        check_value("drop byte_dropped clear", 32'd0, 32'(byte_dropped));
        if (stall) begin
            byte_valid = 1'b1;
            byte_data  = 8'h90;
            @(posedge clk);
            #0.5;
            byte_valid = 1'b0;
        end
        @(posedge clk);
        #0.5;
        check_value("drop byte_dropped set", 32'd1, 32'(byte_dropped));
        issue_en = 1'b1;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // a few more cycles so that any extra record would be caught
        repeat (8) @(posedge clk);
        #0.5;
        check_value("drop byte_dropped held", 32'd1, 32'(byte_dropped));
        check_value("record count", 32'(n_sent), 32'(n_issued));

        $display("errors: %0d value mismatches, %0d other failures", n_fail, n_other);
        if (n_fail == 0 && n_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- prefix_decode_top.f
rtl/prefix_pkg.sv
rtl/prefix_checker.sv
rtl/prefix_scanner.sv
rtl/instr_queue.sv
rtl/prefix_issue.sv
rtl/prefix_decode_top.sv
dv/prefix_decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the prefix decoder and its testbench with verilator and run it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal \
    --top-module prefix_decode_tb \
    -f prefix_decode_top.f \
    --Mdir obj_dir -o prefix_decode_sim > build.log 2>&1 \
    && ./obj_dir/prefix_decode_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "TB PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
